//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench into sim.log and check it"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_decode_stage \
		-Mdir obj_dir -f all.f
	./obj_dir/Vtb_decode_stage | tee sim.log
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
decode_pkg.sv
alu_decoder.sv
flow_decoder.sv
credit_counter.sv
decode_stage.sv
tb_decode_stage.sv

//--- alu_decoder.sv
`timescale 1ns/100ps

module alu_decoder (
    input  decode_pkg::instr_t     instr,
    output decode_pkg::alu_op_t    alu_op,
    output decode_pkg::shift_op_t  shift_op,
    output logic                   shamt_sel,
    output logic                   of_w_disen,
    output logic                   b_sel,
    output decode_pkg::imm_ext_t   imm_ext,
    output logic                   reg_w,
    output decode_pkg::rd_sel_t    rd_addr_sel,
    output decode_pkg::exres_sel_t exres_sel
);
    import decode_pkg::*;

    opcode_t opcode;
    funct_t  funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        alu_op      = ALU_ADDU;
        shift_op    = SHIFT_LEFT;
        shamt_sel   = 1'b0;
        of_w_disen  = 1'b0;
        b_sel       = 1'b0;
        imm_ext     = IMM_ZERO;
        reg_w       = 1'b0;
        rd_addr_sel = RD_RT;
        exres_sel   = EX_ALU;

        case (opcode)
            OP_SPECIAL: begin
                // All-zero word is the NOP, not SLL
                if (instr != '0) begin
                    reg_w       = 1'b1;
                    rd_addr_sel = RD_RD;
                    case (funct)
                        FN_ADD: begin
                            alu_op     = ALU_ADD;
                            of_w_disen = 1'b1;
                        end
                        FN_ADDU: alu_op = ALU_ADDU;
                        FN_SUB: begin
                            alu_op     = ALU_SUB;
                            of_w_disen = 1'b1;
                        end
                        FN_SUBU: alu_op = ALU_SUBU;
                        FN_AND:  alu_op = ALU_AND;
                        FN_OR:   alu_op = ALU_OR;
                        FN_XOR:  alu_op = ALU_XOR;
                        FN_NOR:  alu_op = ALU_NOR;
                        FN_SLT:  alu_op = ALU_SLT;
                        FN_SLTU: alu_op = ALU_SLTU;
                        FN_SLL, FN_SLLV: begin
                            exres_sel = EX_SHIFT;
                            shift_op  = SHIFT_LEFT;
                            shamt_sel = funct[2];  // Variable form takes rs
                        end
                        FN_SRL, FN_SRLV: begin
                            exres_sel = EX_SHIFT;
                            shift_op  = SHIFT_RIGHT_L;
                            shamt_sel = funct[2];
                        end
                        FN_SRA, FN_SRAV: begin
                            exres_sel = EX_SHIFT;
                            shift_op  = SHIFT_RIGHT_A;
                            shamt_sel = funct[2];
                        end
                        default: begin
                            // JR and unknown functions belong elsewhere
                            reg_w       = 1'b0;
                            rd_addr_sel = RD_RT;
                        end
                    endcase
                end
            end
            OP_SPECIAL2: begin
                if (funct == FN_CLO || funct == FN_CLZ) begin
                    reg_w       = 1'b1;
                    rd_addr_sel = RD_RD;
                    alu_op      = (funct == FN_CLO) ? ALU_CLO : ALU_CLZ;
                end
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                reg_w       = 1'b1;
                rd_addr_sel = RD_RT;
                b_sel       = 1'b1;   // Immediate as operand B
                imm_ext     = IMM_SIGN;
                case (opcode)
                    OP_ADDI: begin
                        alu_op     = ALU_ADD;
                        of_w_disen = 1'b1;
                    end
                    OP_ADDIU: alu_op = ALU_ADDU;
                    OP_SLTI:  alu_op = ALU_SLT;
                    OP_SLTIU: alu_op = ALU_SLTU;
                    OP_ANDI: begin
                        alu_op  = ALU_AND;
                        imm_ext = IMM_ZERO;
                    end
                    OP_ORI: begin
                        alu_op  = ALU_OR;
                        imm_ext = IMM_ZERO;
                    end
                    OP_XORI: begin
                        alu_op  = ALU_XOR;
                        imm_ext = IMM_ZERO;
                    end
                    OP_LUI: begin
                        alu_op  = ALU_ADDU;  // Upper half plus zero
                        imm_ext = IMM_UPPER;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- credit_counter.sv
`timescale 1ns/100ps

module credit_counter #(
    parameter int CREDITS = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic take,   // Word sent downstream
    input  logic give,   // Slot freed by the consumer
    output logic avail
);

    // Must hold the full CREDITS value
    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= CNT_W'(CREDITS);
        end else begin
            case ({take, give})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;  // Both cancel out
            endcase
        end
    end

    assign avail = (count != '0);

endmodule

//--- decode_pkg.sv
package decode_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  shift_op_t;
    typedef logic [2:0]  cond_t;
    typedef logic [2:0]  mem_sel_t;
    typedef logic [1:0]  imm_ext_t;
    typedef logic [1:0]  rd_sel_t;
    typedef logic [1:0]  exres_sel_t;

    // ALU operation codes
    localparam alu_op_t ALU_ADDU = 4'd0;
    localparam alu_op_t ALU_SUBU = 4'd1;
    localparam alu_op_t ALU_CLZ  = 4'd2;
    localparam alu_op_t ALU_CLO  = 4'd3;
    localparam alu_op_t ALU_AND  = 4'd4;
    localparam alu_op_t ALU_SLT  = 4'd5;
    localparam alu_op_t ALU_OR   = 4'd6;
    localparam alu_op_t ALU_SLTU = 4'd7;
    localparam alu_op_t ALU_NOR  = 4'd8;
    localparam alu_op_t ALU_XOR  = 4'd9;
    localparam alu_op_t ALU_ADD  = 4'd14;  // Traps on overflow
    localparam alu_op_t ALU_SUB  = 4'd15;

    // Primary opcodes
    localparam opcode_t OP_SPECIAL  = 6'd0;
    localparam opcode_t OP_REGIMM   = 6'd1;
    localparam opcode_t OP_J        = 6'd2;
    localparam opcode_t OP_JAL      = 6'd3;
    localparam opcode_t OP_BEQ      = 6'd4;
    localparam opcode_t OP_BNE      = 6'd5;
    localparam opcode_t OP_BLEZ     = 6'd6;
    localparam opcode_t OP_BGTZ     = 6'd7;
    localparam opcode_t OP_ADDI     = 6'd8;
    localparam opcode_t OP_ADDIU    = 6'd9;
    localparam opcode_t OP_SLTI     = 6'd10;
    localparam opcode_t OP_SLTIU    = 6'd11;
    localparam opcode_t OP_ANDI     = 6'd12;
    localparam opcode_t OP_ORI      = 6'd13;
    localparam opcode_t OP_XORI     = 6'd14;
    localparam opcode_t OP_LUI      = 6'd15;
    localparam opcode_t OP_SPECIAL2 = 6'd28;
    localparam opcode_t OP_LB       = 6'd32;
    localparam opcode_t OP_LH       = 6'd33;
    localparam opcode_t OP_LWL      = 6'd34;
    localparam opcode_t OP_LW       = 6'd35;
    localparam opcode_t OP_LBU      = 6'd36;
    localparam opcode_t OP_LHU      = 6'd37;
    localparam opcode_t OP_LWR      = 6'd38;
    localparam opcode_t OP_SB       = 6'd40;
    localparam opcode_t OP_SH       = 6'd41;
    localparam opcode_t OP_SWL      = 6'd42;
    localparam opcode_t OP_SW       = 6'd43;
    localparam opcode_t OP_SWR      = 6'd46;

    // SPECIAL function field
    localparam funct_t FN_SLL  = 6'd0;
    localparam funct_t FN_SRL  = 6'd2;
    localparam funct_t FN_SRA  = 6'd3;
    localparam funct_t FN_SLLV = 6'd4;
    localparam funct_t FN_SRLV = 6'd6;
    localparam funct_t FN_SRAV = 6'd7;
    localparam funct_t FN_JR   = 6'd8;
    localparam funct_t FN_ADD  = 6'd32;
    localparam funct_t FN_ADDU = 6'd33;
    localparam funct_t FN_SUB  = 6'd34;
    localparam funct_t FN_SUBU = 6'd35;
    localparam funct_t FN_AND  = 6'd36;
    localparam funct_t FN_OR   = 6'd37;
    localparam funct_t FN_XOR  = 6'd38;
    localparam funct_t FN_NOR  = 6'd39;
    localparam funct_t FN_SLT  = 6'd42;
    localparam funct_t FN_SLTU = 6'd43;
    // SPECIAL2 function field
    localparam funct_t FN_CLZ  = 6'd32;
    localparam funct_t FN_CLO  = 6'd33;

    localparam shift_op_t SHIFT_LEFT    = 2'd0;
    localparam shift_op_t SHIFT_RIGHT_L = 2'd1;
    localparam shift_op_t SHIFT_RIGHT_A = 2'd2;

    // Branch conditions
    localparam cond_t COND_NONE = 3'd0;
    localparam cond_t COND_BEQ  = 3'd1;
    localparam cond_t COND_BNE  = 3'd2;
    localparam cond_t COND_BGEZ = 3'd3;
    localparam cond_t COND_BGTZ = 3'd4;
    localparam cond_t COND_BLEZ = 3'd5;
    localparam cond_t COND_BLTZ = 3'd6;

    // Load widths
    localparam mem_sel_t LD_B  = 3'd0;
    localparam mem_sel_t LD_BU = 3'd1;
    localparam mem_sel_t LD_H  = 3'd2;
    localparam mem_sel_t LD_HU = 3'd3;
    localparam mem_sel_t LD_W  = 3'd4;
    localparam mem_sel_t LD_WL = 3'd5;
    localparam mem_sel_t LD_WR = 3'd6;

    // Store widths
    localparam mem_sel_t ST_B  = 3'd0;
    localparam mem_sel_t ST_H  = 3'd1;
    localparam mem_sel_t ST_W  = 3'd2;
    localparam mem_sel_t ST_WL = 3'd3;
    localparam mem_sel_t ST_WR = 3'd4;

    localparam imm_ext_t IMM_ZERO  = 2'd0;
    localparam imm_ext_t IMM_SIGN  = 2'd1;
    localparam imm_ext_t IMM_UPPER = 2'd2;  // LUI
    localparam imm_ext_t IMM_JUMP  = 2'd3;

    localparam rd_sel_t RD_RT   = 2'd0;
    localparam rd_sel_t RD_RD   = 2'd1;
    localparam rd_sel_t RD_LINK = 2'd2;

    localparam exres_sel_t EX_ALU   = 2'd0;
    localparam exres_sel_t EX_SHIFT = 2'd1;
    localparam exres_sel_t EX_LINK  = 2'd2;

endpackage

//--- decode_stage.sv
`timescale 1ns/100ps

module decode_stage #(
    parameter int CREDITS = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  decode_pkg::instr_t     instr,
    input  logic                   instr_valid,
    output logic                   instr_ready,
    input  logic                   credit_return,
    output logic                   out_valid,
    output decode_pkg::alu_op_t    alu_op,
    output decode_pkg::shift_op_t  shift_op,
    output logic                   shamt_sel,
    output logic                   of_w_disen,
    output logic                   b_sel,
    output decode_pkg::imm_ext_t   imm_ext,
    output logic                   reg_w,
    output decode_pkg::rd_sel_t    rd_addr_sel,
    output decode_pkg::exres_sel_t exres_sel,
    output logic                   branch,
    output decode_pkg::cond_t      condition,
    output logic                   jump,
    output logic                   jr,
    output logic                   mem_r,
    output logic                   mem_w,
    output decode_pkg::mem_sel_t   load_sel,
    output decode_pkg::mem_sel_t   store_sel,
    output decode_pkg::shamt_t     shamt
);
    import decode_pkg::*;

    logic accept;

    // Execute-side fields
    alu_op_t    a_alu_op;
    shift_op_t  a_shift_op;
    logic       a_shamt_sel;
    logic       a_of_w_disen;
    logic       a_b_sel;
    imm_ext_t   a_imm_ext;
    logic       a_reg_w;
    rd_sel_t    a_rd_addr_sel;
    exres_sel_t a_exres_sel;

    // Control-flow and memory fields
    logic       f_branch;
    cond_t      f_condition;
    logic       f_jump;
    logic       f_jr;
    logic       f_mem_r;
    logic       f_mem_w;
    mem_sel_t   f_load_sel;
    mem_sel_t   f_store_sel;
    alu_op_t    f_alu_op;
    logic       f_b_sel;
    imm_ext_t   f_imm_ext;
    logic       f_reg_w;
    rd_sel_t    f_rd_addr_sel;
    exres_sel_t f_exres_sel;

    assign accept = instr_valid && instr_ready;

    alu_decoder i_alu_decoder (
        .instr       (instr),
        .alu_op      (a_alu_op),
        .shift_op    (a_shift_op),
        .shamt_sel   (a_shamt_sel),
        .of_w_disen  (a_of_w_disen),
        .b_sel       (a_b_sel),
        .imm_ext     (a_imm_ext),
        .reg_w       (a_reg_w),
        .rd_addr_sel (a_rd_addr_sel),
        .exres_sel   (a_exres_sel)
    );

    flow_decoder i_flow_decoder (
        .instr       (instr),
        .branch      (f_branch),
        .condition   (f_condition),
        .jump        (f_jump),
        .jr          (f_jr),
        .mem_r       (f_mem_r),
        .mem_w       (f_mem_w),
        .load_sel    (f_load_sel),
        .store_sel   (f_store_sel),
        .alu_op      (f_alu_op),
        .b_sel       (f_b_sel),
        .imm_ext     (f_imm_ext),
        .reg_w       (f_reg_w),
        .rd_addr_sel (f_rd_addr_sel),
        .exres_sel   (f_exres_sel)
    );

    credit_counter #(
        .CREDITS (CREDITS)
    ) i_credit_counter (
        .clk   (clk),
        .rst   (rst),
        .take  (accept),
        .give  (credit_return),
        .avail (instr_ready)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= accept;
        end
    end

    // Groups never overlap, so OR merges the two decoders
    always_ff @(posedge clk) begin
        if (accept) begin
            alu_op      <= a_alu_op | f_alu_op;
            shift_op    <= a_shift_op;
            shamt_sel   <= a_shamt_sel;
            of_w_disen  <= a_of_w_disen;
            b_sel       <= a_b_sel | f_b_sel;
            imm_ext     <= a_imm_ext | f_imm_ext;
            reg_w       <= a_reg_w | f_reg_w;
            rd_addr_sel <= a_rd_addr_sel | f_rd_addr_sel;
            exres_sel   <= a_exres_sel | f_exres_sel;
            branch      <= f_branch;
            condition   <= f_condition;
            jump        <= f_jump;
            jr          <= f_jr;
            mem_r       <= f_mem_r;
            mem_w       <= f_mem_w;
            load_sel    <= f_load_sel;
            store_sel   <= f_store_sel;
            shamt       <= instr[10:6];
        end
    end

endmodule

//--- flow_decoder.sv
`timescale 1ns/100ps

module flow_decoder (
    input  decode_pkg::instr_t     instr,
    output logic                   branch,
    output decode_pkg::cond_t      condition,
    output logic                   jump,
    output logic                   jr,
    output logic                   mem_r,
    output logic                   mem_w,
    output decode_pkg::mem_sel_t   load_sel,
    output decode_pkg::mem_sel_t   store_sel,
    output decode_pkg::alu_op_t    alu_op,
    output logic                   b_sel,
    output decode_pkg::imm_ext_t   imm_ext,
    output logic                   reg_w,
    output decode_pkg::rd_sel_t    rd_addr_sel,
    output decode_pkg::exres_sel_t exres_sel
);
    import decode_pkg::*;

    opcode_t opcode;
    funct_t  funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        branch      = 1'b0;
        condition   = COND_NONE;
        jump        = 1'b0;
        jr          = 1'b0;
        mem_r       = 1'b0;
        mem_w       = 1'b0;
        load_sel    = LD_B;
        store_sel   = ST_B;
        alu_op      = ALU_ADDU;
        b_sel       = 1'b0;
        imm_ext     = IMM_ZERO;
        reg_w       = 1'b0;
        rd_addr_sel = RD_RT;
        exres_sel   = EX_ALU;

        case (opcode)
            OP_SPECIAL: begin
                if (funct == FN_JR) begin
                    branch = 1'b1;
                    jr     = 1'b1;  // Target from rs
                end
            end
            OP_REGIMM, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                branch  = 1'b1;
                alu_op  = ALU_SUBU;  // Compare by subtraction
                imm_ext = IMM_SIGN;
                case (opcode)
                    OP_BEQ:  condition = COND_BEQ;
                    OP_BNE:  condition = COND_BNE;
                    OP_BLEZ: condition = COND_BLEZ;
                    OP_BGTZ: condition = COND_BGTZ;
                    // In REGIMM rt bit 0 selects BGEZ
                    default: condition = instr[16] ? COND_BGEZ : COND_BLTZ;
                endcase
            end
            OP_J: begin
                jump    = 1'b1;
                imm_ext = IMM_JUMP;
            end
            OP_JAL: begin
                jump        = 1'b1;
                imm_ext     = IMM_JUMP;
                reg_w       = 1'b1;
                rd_addr_sel = RD_LINK;  // Return address to r31
                exres_sel   = EX_LINK;
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR: begin
                mem_r       = 1'b1;
                reg_w       = 1'b1;
                rd_addr_sel = RD_RT;
                b_sel       = 1'b1;
                imm_ext     = IMM_SIGN;  // Base plus offset
                case (opcode)
                    OP_LB:   load_sel = LD_B;
                    OP_LBU:  load_sel = LD_BU;
                    OP_LH:   load_sel = LD_H;
                    OP_LHU:  load_sel = LD_HU;
                    OP_LW:   load_sel = LD_W;
                    OP_LWL:  load_sel = LD_WL;
                    OP_LWR:  load_sel = LD_WR;
                    default: ;
                endcase
            end
            OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR: begin
                mem_w   = 1'b1;
                b_sel   = 1'b1;
                imm_ext = IMM_SIGN;
                case (opcode)
                    OP_SB:   store_sel = ST_B;
                    OP_SH:   store_sel = ST_H;
                    OP_SW:   store_sel = ST_W;
                    OP_SWL:  store_sel = ST_WL;
                    OP_SWR:  store_sel = ST_WR;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

//--- tb_decode_stage.sv
`timescale 1ns/100ps

module tb_decode_stage;

    localparam int CREDITS = 4;
    localparam int TIMEOUT = 1000;  // Cycles per wait loop

    localparam logic [5:0] FN_EXEC [16] = '{6'd32, 6'd33, 6'd34, 6'd35, 6'd36, 6'd37,
        6'd38, 6'd39, 6'd42, 6'd43, 6'd0, 6'd2, 6'd3, 6'd4, 6'd6, 6'd7};
    localparam logic [5:0] BR_OPS [5] = '{6'd1, 6'd4, 6'd5, 6'd6, 6'd7};
    localparam logic [5:0] ST_OPS [5] = '{6'd40, 6'd41, 6'd42, 6'd43, 6'd46};

    typedef struct packed {
        logic [3:0] alu_op;
        logic [1:0] shift_op;
        logic       shamt_sel;
        logic       of_w_disen;
        logic       b_sel;
        logic [1:0] imm_ext;
        logic       reg_w;
        logic [1:0] rd_addr_sel;
        logic [1:0] exres_sel;
        logic       branch;
        logic [2:0] condition;
        logic       jump;
        logic       jr;
        logic       mem_r;
        logic       mem_w;
        logic [2:0] load_sel;
        logic [2:0] store_sel;
        logic [4:0] shamt;
    } ctrl_t;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic        instr_valid;
    logic        instr_ready;
    logic        credit_return;
    logic        out_valid;
    logic [3:0]  alu_op;
    logic [1:0]  shift_op;
    logic        shamt_sel;
    logic        of_w_disen;
    logic        b_sel;
    logic [1:0]  imm_ext;
    logic        reg_w;
    logic [1:0]  rd_addr_sel;
    logic [1:0]  exres_sel;
    logic        branch;
    logic [2:0]  condition;
    logic        jump;
    logic        jr;
    logic        mem_r;
    logic        mem_w;
    logic [2:0]  load_sel;
    logic [2:0]  store_sel;
    logic [4:0]  shamt;

    integer      seed;
    ctrl_t       exp_q[$];
    logic [31:0] word_q[$];
    int          errors = 0;
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          received = 0;
    int          outstanding = 0;   // Accepted and not yet credited
    int          owed = 0;          // Received and not yet credited
    int          manual_credits = 0;
    int          taken;
    logic        hold_credits = 1'b0;
    logic        give_next = 1'b0;
    logic        accept_prev = 1'b0;
    logic        timed_out = 1'b0;

    decode_stage #(
        .CREDITS (CREDITS)
    ) i_decode_stage (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int unsigned pick(input int unsigned n);
        pick = $unsigned($random(seed)) % n;
    endfunction

    // Expected control word from the decode rules
    function automatic ctrl_t decode_ref(input logic [31:0] w);
        ctrl_t c;
        logic [5:0] op;
        logic [5:0] fn;
        logic hit;
        op = w[31:26];
        fn = w[5:0];
        c = '0;
        c.shamt = w[10:6];
        case (op)
            6'd0: begin
                hit = (w != 32'd0);  // NOP decodes to nothing
                case (fn)
                    6'd32: c.alu_op = 4'd14;
                    6'd33: c.alu_op = 4'd0;
                    6'd34: c.alu_op = 4'd15;
                    6'd35: c.alu_op = 4'd1;
                    6'd36: c.alu_op = 4'd4;
                    6'd37: c.alu_op = 4'd6;
                    6'd38: c.alu_op = 4'd9;
                    6'd39: c.alu_op = 4'd8;
                    6'd42: c.alu_op = 4'd5;
                    6'd43: c.alu_op = 4'd7;
                    6'd0, 6'd4: c.shift_op = 2'd0;
                    6'd2, 6'd6: c.shift_op = 2'd1;
                    6'd3, 6'd7: c.shift_op = 2'd2;
                    6'd8: begin
                        c.branch = 1'b1;
                        c.jr = 1'b1;
                        hit = 1'b0;
                    end
                    default: hit = 1'b0;
                endcase
                if (hit) begin
                    c.reg_w = 1'b1;
                    c.rd_addr_sel = 2'd1;
                    c.of_w_disen = (fn == 6'd32 || fn == 6'd34);
                    if (fn <= 6'd7) begin
                        c.exres_sel = 2'd1;
                        // SLLV, SRLV, SRAV
                        c.shamt_sel = (fn == 6'd4 || fn == 6'd6 || fn == 6'd7);
                    end
                end
            end
            6'd28: begin
                if (fn == 6'd32 || fn == 6'd33) begin
                    c.alu_op = (fn == 6'd33) ? 4'd3 : 4'd2;
                    c.reg_w = 1'b1;
                    c.rd_addr_sel = 2'd1;
                end
            end
            6'd8, 6'd9, 6'd10, 6'd11, 6'd12, 6'd13, 6'd14, 6'd15: begin
                c.reg_w = 1'b1;
                c.b_sel = 1'b1;
                c.imm_ext = 2'd1;
                case (op[2:0])
                    3'd0: c.alu_op = 4'd14;
                    3'd2: c.alu_op = 4'd5;
                    3'd3: c.alu_op = 4'd7;
                    3'd4: c.alu_op = 4'd4;
                    3'd5: c.alu_op = 4'd6;
                    3'd6: c.alu_op = 4'd9;
                    default: c.alu_op = 4'd0;  // ADDIU, LUI
                endcase
                c.of_w_disen = (op == 6'd8);
                if (op >= 6'd12 && op <= 6'd14) begin
                    c.imm_ext = 2'd0;
                end
                if (op == 6'd15) begin
                    c.imm_ext = 2'd2;
                end
            end
            6'd1, 6'd4, 6'd5, 6'd6, 6'd7: begin
                c.branch = 1'b1;
                c.alu_op = 4'd1;
                c.imm_ext = 2'd1;
                case (op)
                    6'd4: c.condition = 3'd1;
                    6'd5: c.condition = 3'd2;
                    6'd6: c.condition = 3'd5;
                    6'd7: c.condition = 3'd4;
                    default: c.condition = w[16] ? 3'd3 : 3'd6;
                endcase
            end
            6'd2, 6'd3: begin
                c.jump = 1'b1;
                c.imm_ext = 2'd3;
                if (op == 6'd3) begin
                    c.reg_w = 1'b1;
                    c.rd_addr_sel = 2'd2;
                    c.exres_sel = 2'd2;
                end
            end
            6'd32, 6'd33, 6'd34, 6'd35, 6'd36, 6'd37, 6'd38: begin
                c.mem_r = 1'b1;
                c.reg_w = 1'b1;
                c.b_sel = 1'b1;
                c.imm_ext = 2'd1;
                case (op)
                    6'd32: c.load_sel = 3'd0;
                    6'd36: c.load_sel = 3'd1;
                    6'd33: c.load_sel = 3'd2;
                    6'd37: c.load_sel = 3'd3;
                    6'd35: c.load_sel = 3'd4;
                    6'd34: c.load_sel = 3'd5;
                    default: c.load_sel = 3'd6;
                endcase
            end
            6'd40, 6'd41, 6'd42, 6'd43, 6'd46: begin
                c.mem_w = 1'b1;
                c.b_sel = 1'b1;
                c.imm_ext = 2'd1;
                case (op)
                    6'd40: c.store_sel = 3'd0;
                    6'd41: c.store_sel = 3'd1;
                    6'd43: c.store_sel = 3'd2;
                    6'd42: c.store_sel = 3'd3;
                    default: c.store_sel = 3'd4;
                endcase
            end
            default: ;
        endcase
        return c;
    endfunction

    function automatic logic is_legal(input logic [5:0] op);
        return op <= 6'd15 || op == 6'd28 || (op >= 6'd32 && op <= 6'd38)
            || (op >= 6'd40 && op <= 6'd43) || op == 6'd46;
    endfunction

    function automatic logic [31:0] gen_exec();
        logic [31:0] w;
        w = $random(seed);
        case (pick(3))
            0: begin
                w[31:26] = 6'd0;
                w[5:0] = FN_EXEC[4'(pick(16))];
            end
            1: begin
                w[31:26] = 6'd28;
                w[5:0] = 6'd32 + 6'(pick(2));
            end
            default: w[31:26] = 6'd8 + 6'(pick(8));
        endcase
        return w;
    endfunction

    function automatic logic [31:0] gen_flow();
        logic [31:0] w;
        w = $random(seed);
        case (pick(5))
            0: w[31:26] = BR_OPS[3'(pick(5))];
            1: w[31:26] = 6'd2 + 6'(pick(2));
            2: begin
                w[31:26] = 6'd0;
                w[5:0] = 6'd8;  // JR
            end
            3: w[31:26] = 6'd32 + 6'(pick(7));
            default: w[31:26] = ST_OPS[3'(pick(5))];
        endcase
        return w;
    endfunction

    // Zero word or an unused opcode
    function automatic logic [31:0] gen_odd();
        logic [31:0] w;
        logic [5:0] op;
        w = $random(seed);
        if (pick(4) == 0) begin
            return 32'd0;
        end
        do begin
            op = 6'(pick(64));
        end while (is_legal(op));
        w[31:26] = op;
        return w;
    endfunction

    task automatic give_up(input string why);
        errors++;
        timed_out = 1'b1;
        $display("Timeout at %0t: %s", $time, why);
    endtask

    task automatic queue_word(input logic [31:0] w);
        exp_q.push_back(decode_ref(w));
        word_q.push_back(w);
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic send(input logic [31:0] w);
        int waited;
        waited = 0;
        if (timed_out) begin
            return;
        end
        instr = w;
        instr_valid = 1'b1;
        while (!instr_ready && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!instr_ready) begin
            instr_valid = 1'b0;
            give_up("instr_ready never came back");
        end else begin
            queue_word(w);
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        if (timed_out) begin
            return;
        end
        while ((exp_q.size() != 0 || outstanding != 0) && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0 || outstanding != 0) begin
            give_up("decoded words or credits never came back");
        end
    endtask

    // Keeps instr_valid high and counts accepts in taken
    task automatic offer(input int cycles);
        logic took;
        repeat (cycles) begin
            took = instr_ready;
            if (took) begin
                queue_word(instr);
                taken++;
            end
            @(posedge clk);
            #1;
            if (took) begin
                instr = gen_flow();
            end
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic check_output();
        ctrl_t got_c;
        ctrl_t want;
        logic [31:0] w;
        got_c = {alu_op, shift_op, shamt_sel, of_w_disen, b_sel, imm_ext, reg_w, rd_addr_sel,
            exres_sel, branch, condition, jump, jr, mem_r, mem_w, load_sel, store_sel, shamt};
        assert (exp_q.size() != 0) else begin
            errors++;
            $display("Error at %0t: a decoded word came out with nothing pending", $time);
        end
        if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            w = word_q.pop_front();
            received++;
            owed++;
            assert (got_c == want) else begin
                errors++;
                $display("Fail at %0t: instr %h decoded to %h, expected %h",
                    $time, w, got_c, want);
            end
        end
    endtask

    // Downstream side sampled on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            assert (out_valid == accept_prev) else begin
                errors++;
                $display("Fail at %0t: out_valid %0b, expected %0b",
                    $time, out_valid, accept_prev);
            end
            if (out_valid) begin
                check_output();
            end
            assert (instr_ready == (outstanding < CREDITS)) else begin
                errors++;
                $display("Fail at %0t: instr_ready %0b with %0d words outstanding",
                    $time, instr_ready, outstanding);
            end
            accept_prev = instr_valid && instr_ready;
            outstanding = outstanding + (accept_prev ? 1 : 0) - (credit_return ? 1 : 0);
            assert (outstanding <= CREDITS) else begin
                errors++;
                $display("Fail at %0t: %0d words outstanding", $time, outstanding);
            end
            give_next = 1'b0;
            if (owed > 0) begin
                if (hold_credits) begin
                    if (manual_credits > 0) begin
                        give_next = 1'b1;
                        manual_credits--;
                    end
                end else begin
                    give_next = (pick(3) == 0);
                end
                if (give_next) begin
                    owed--;
                end
            end
        end
    end

    initial begin
        credit_return = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            credit_return = give_next;
        end
    end

    initial begin
        seed = 32'h670c21a7;
        rst = 1'b1;
        instr = 32'd0;
        instr_valid = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        assert (!out_valid && instr_ready) else begin
            errors++;
            $display("Fail at %0t: out_valid %0b instr_ready %0b after reset",
                $time, out_valid, instr_ready);
        end
        end_test("reset state");

        repeat (60) send(gen_exec());
        drain();
        end_test("ALU, shift, count and immediate words");

        repeat (60) send(gen_flow());
        drain();
        end_test("branch, jump, load and store words");

        repeat (30) send(gen_odd());
        drain();
        end_test("zero word and illegal opcodes");

        hold_credits = 1'b1;
        taken = 0;
        instr = gen_exec();
        instr_valid = 1'b1;
        offer(12);
        assert (taken == CREDITS && !instr_ready) else begin
            errors++;
            $display("Fail at %0t: %0d accepts with credits held, expected %0d",
                $time, taken, CREDITS);
        end
        manual_credits = 1;
        offer(12);
        assert (taken == CREDITS + 1 && !instr_ready) else begin
            errors++;
            $display("Fail at %0t: %0d accepts after one credit, expected %0d",
                $time, taken, CREDITS + 1);
        end
        instr_valid = 1'b0;
        hold_credits = 1'b0;
        drain();
        end_test("credit back-pressure");

        repeat (200) begin
            if (pick(4) == 0) begin
                @(posedge clk);
                #1;
            end
            case (pick(3))
                0: send(gen_exec());
                1: send(gen_flow());
                default: send(gen_odd());
            endcase
        end
        drain();
        end_test("random credit returns");

        $display("%0d tests, %0d failed, %0d errors, %0d words checked",
            tests_run, tests_bad, errors, received);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
